// ==== hdl/dfe_cal_pkg.sv ====
// ########################################
// dfe calibration constants, register map,
// opcode, mode and sequencer state types
// ########################################
package dfe_cal_pkg;

    // bus and channel widths
    localparam int CTRL_ADDR_W = 12;
    localparam int CTRL_DATA_W = 16;
    localparam int PHYS_W      = 7;
    localparam int UIF_ADDR_W  = 6;

    // offset search
    localparam int LANES     = 6;
    localparam int OFFSET_W  = 4;
    localparam int STEP_W    = 5;
    localparam int NUM_STEPS = 16;
    localparam logic [OFFSET_W-1:0] OFFSET_MID = 4'd8;

    // hardware reaction time, then the window in which toggles count
    localparam int HW_SETTLE   = 80;
    localparam int SAMPLE_TIME = 32;
    localparam int WAIT_DELAY  = HW_SETTLE + SAMPLE_TIME;
    localparam int WAIT_W      = $clog2(WAIT_DELAY);

    // basic-block register addresses
    localparam logic [CTRL_ADDR_W-1:0] ADDR_DFE8  = 12'h108;
    localparam logic [CTRL_ADDR_W-1:0] ADDR_DFE11 = 12'h10b;
    localparam logic [CTRL_ADDR_W-1:0] ADDR_DFE12 = 12'h10c;
    localparam logic [CTRL_ADDR_W-1:0] ADDR_DFE13 = 12'h10d;
    localparam logic [CTRL_ADDR_W-1:0] ADDR_DFE15 = 12'h10f;
    localparam logic [CTRL_ADDR_W-1:0] ADDR_OC    = 12'h1a0;

    // user dfe control register offset
    localparam logic [UIF_ADDR_W-1:0] USER_CTRL_ADDR = 6'h0a;

    localparam logic [CTRL_DATA_W-1:0] TESTBUS_SEL = 16'h000d;

    // register bit positions
    localparam int DFE8_TB_OE    = 2;
    localparam int DFE11_ADAPT   = 15;
    localparam int DFE12_PDB     = 7;
    localparam int DFE12_OD_LO   = 12;
    localparam int DFE12_EV_LO   = 8;
    localparam int DFE13_BYPASS  = 0;
    localparam int DFE13_VREF_LO = 13;
    localparam int OC_CALEN      = 4;

    // user data bits
    localparam int UIF_ADAPT = 0;
    localparam int UIF_PDB   = 1;

    typedef enum logic [2:0] {
        CTRL_OP_RD   = 3'b000,
        CTRL_OP_WR   = 3'b001,
        CTRL_OP_TBUS = 3'b011
    } ctrl_op_t;

    typedef enum logic [2:0] {
        UIF_MODE_RD   = 3'b000,
        UIF_MODE_WR   = 3'b001,
        UIF_MODE_PHYS = 3'b010
    } uif_mode_t;

    typedef enum logic [4:0] {
        ST_IDLE, ST_RD_PWR, ST_WR_PWR, ST_RD_VREF, ST_WR_VREF,
        ST_RD_ADPT_ON, ST_WR_ADPT_ON, ST_TESTBUS, ST_RD_TB_ON, ST_WR_TB_ON,
        ST_RD_OC_ON, ST_WR_OC_ON, ST_RD_OFFSET12, ST_WR_OFFSET12, ST_WR_OFFSET15,
        ST_WAIT, ST_RD_TB_OFF, ST_WR_TB_OFF, ST_RD_OC_OFF, ST_WR_OC_OFF,
        ST_WR_VREF2, ST_RD_ADPT, ST_WR_ADPT
    } cal_state_t;

endpackage

// ==== hdl/offset_lane.sv ====
// ########################################
// one testbus lane: toggle detect, midpoint
// ########################################
`timescale 1ns/1ps

module offset_lane (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clear,
    input  logic                                sample_window,
    input  logic                                step_tick,
    input  logic [dfe_cal_pkg::STEP_W-1:0]      step,
    input  logic                                testbus_bit,
    output logic [dfe_cal_pkg::OFFSET_W-1:0]    code,
    output logic                                done
);
    import dfe_cal_pkg::*;

    logic                 bit_prev;
    logic                 toggled;
    logic                 toggle_now;
    logic                 hit;
    logic                 found;
    logic [OFFSET_W-1:0]  cur;
    logic [OFFSET_W-1:0]  first_step;
    logic [OFFSET_W-1:0]  last_step;
    logic [OFFSET_W-1:0]  first_nxt;
    logic [OFFSET_W-1:0]  last_nxt;
    logic [OFFSET_W:0]    mid_sum;
    logic [OFFSET_W-1:0]  result;

    assign cur        = step[OFFSET_W-1:0];
    assign toggle_now = sample_window && (testbus_bit != bit_prev);
    // include the tick cycle's own sample
    assign hit        = toggled || toggle_now;
    assign first_nxt  = found ? first_step : cur;
    assign last_nxt   = hit ? cur : last_step;
    assign mid_sum    = {1'b0, first_nxt} + {1'b0, last_nxt};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            bit_prev   <= 1'b0;
            toggled    <= 1'b0;
            found      <= 1'b0;
            first_step <= '0;
            last_step  <= '0;
            result     <= '0;
            done       <= 1'b0;
        end
        else if (clear)
        begin
            bit_prev   <= testbus_bit;
            toggled    <= 1'b0;
            found      <= 1'b0;
            first_step <= '0;
            last_step  <= '0;
            result     <= '0;
            done       <= 1'b0;
        end
        else
        begin
            bit_prev <= testbus_bit;
            if (step_tick && !done)
            begin
                toggled <= 1'b0;
                if (hit)
                begin
                    found      <= 1'b1;
                    first_step <= first_nxt;
                    last_step  <= cur;
                end
                // last code: midpoint rounded down, midscale if never toggled
                if (step == STEP_W'(NUM_STEPS - 1))
                begin
                    done   <= 1'b1;
                    result <= (found || hit) ? mid_sum[OFFSET_W:1] : OFFSET_MID;
                end
            end
            else if (toggle_now)
                toggled <= 1'b1;
        end
    end

    assign code = done ? result : cur;

endmodule

// ==== hdl/offset_search.sv ====
// ########################################
// settle/sample timer, step counter, lanes
// ########################################
`timescale 1ns/1ps

module offset_search (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  search_clear,
    input  logic                                                  search_run,
    input  logic [dfe_cal_pkg::LANES-1:0]                         ctrl_testbus,
    output logic                                                  step_tick,
    output logic                                                  search_done,
    output logic [dfe_cal_pkg::LANES-1:0][dfe_cal_pkg::OFFSET_W-1:0] lane_code
);
    import dfe_cal_pkg::*;

    logic [WAIT_W-1:0]  timer;
    logic [STEP_W-1:0]  step;
    logic               sample_window;
    logic [LANES-1:0]   lane_done;

    // timer runs only during the wait state
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            timer <= '0;
        else if (!search_run || step_tick)
            timer <= '0;
        else
            timer <= timer + 1'b1;
    end

    assign step_tick     = search_run && (timer == WAIT_W'(WAIT_DELAY - 1));
    assign sample_window = search_run && (timer >= WAIT_W'(HW_SETTLE));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            step <= '0;
        else if (search_clear)
            step <= '0;
        else if (step_tick)
            step <= step + 1'b1;
    end

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        offset_lane offset_lane_inst (
            .clk           (clk),
            .reset         (reset),
            .clear         (search_clear),
            .sample_window (sample_window),
            .step_tick     (step_tick),
            .step          (step),
            .testbus_bit   (ctrl_testbus[i]),
            .code          (lane_code[i]),
            .done          (lane_done[i])
        );
    end

    assign search_done = &lane_done;

endmodule

// ==== hdl/cal_sequencer.sv ====
// ########################################
// calibration FSM, bus done and go/lock/busy,
// per-channel calibrated memory
// ########################################
`timescale 1ns/1ps

module cal_sequencer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 uif_go,
    input  dfe_cal_pkg::uif_mode_t               uif_mode,
    input  logic [dfe_cal_pkg::UIF_ADDR_W-1:0]   uif_addr,
    input  logic                                 uif_pdb,
    input  logic                                 uif_chan_err,
    input  logic                                 ctrl_wait,
    input  logic [dfe_cal_pkg::CTRL_DATA_W-1:0]  ctrl_rdata,
    input  logic [dfe_cal_pkg::PHYS_W-1:0]       ctrl_phys,
    input  logic                                 step_tick,
    input  logic                                 search_done,
    output dfe_cal_pkg::cal_state_t              state,
    output logic                                 uif_busy,
    output logic                                 ctrl_go,
    output logic                                 ctrl_lock,
    output logic                                 search_clear,
    output logic                                 search_run,
    output logic [dfe_cal_pkg::CTRL_DATA_W-1:0]  rmw_data_save
);
    import dfe_cal_pkg::*;

    cal_state_t               next_state;
    cal_state_t               state_nxt;
    logic                     accept;
    logic                     bus_pending;
    logic                     ctrl_done;
    logic                     ctrl_go_ff;
    logic [2**PHYS_W-1:0]     cal_mem;
    logic                     cal_prior;

    // only a user write to the control register starts a sequence
    assign accept = uif_go && (uif_mode == UIF_MODE_WR) && (uif_addr == USER_CTRL_ADDR);

    // done follows the first cycle with wait low after go
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            bus_pending <= 1'b0;
            ctrl_done   <= 1'b0;
        end
        else
        begin
            ctrl_done <= bus_pending & ~ctrl_wait;
            if (ctrl_go)
                bus_pending <= 1'b1;
            else if (!ctrl_wait)
                bus_pending <= 1'b0;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:        if (accept) next_state = ST_RD_PWR;
            ST_RD_PWR:      if (ctrl_done) next_state = ST_WR_PWR;
            ST_WR_PWR:      if (ctrl_done) next_state = ST_RD_VREF;
            // calibrate only on first power-up of this channel
            ST_RD_VREF:     if (ctrl_done)
                                next_state = (uif_pdb && !cal_prior) ? ST_WR_VREF : ST_WR_VREF2;
            ST_WR_VREF:     if (ctrl_done) next_state = ST_RD_ADPT_ON;
            ST_RD_ADPT_ON:  if (ctrl_done) next_state = ST_WR_ADPT_ON;
            ST_WR_ADPT_ON:  if (ctrl_done) next_state = ST_TESTBUS;
            ST_TESTBUS:     if (ctrl_done) next_state = ST_RD_TB_ON;
            ST_RD_TB_ON:    if (ctrl_done) next_state = ST_WR_TB_ON;
            ST_WR_TB_ON:    if (ctrl_done) next_state = ST_RD_OC_ON;
            ST_RD_OC_ON:    if (ctrl_done) next_state = ST_WR_OC_ON;
            ST_WR_OC_ON:    if (ctrl_done) next_state = ST_RD_OFFSET12;
            ST_RD_OFFSET12: if (ctrl_done) next_state = ST_WR_OFFSET12;
            // sweep loop
            ST_WR_OFFSET12: if (ctrl_done) next_state = ST_WR_OFFSET15;
            ST_WR_OFFSET15: if (ctrl_done)
                                next_state = search_done ? ST_RD_TB_OFF : ST_WAIT;
            ST_WAIT:        if (step_tick) next_state = ST_WR_OFFSET12;
            // undo testbus and OC settings, then restore user bits
            ST_RD_TB_OFF:   if (ctrl_done) next_state = ST_WR_TB_OFF;
            ST_WR_TB_OFF:   if (ctrl_done) next_state = ST_RD_OC_OFF;
            ST_RD_OC_OFF:   if (ctrl_done) next_state = ST_WR_OC_OFF;
            ST_WR_OC_OFF:   if (ctrl_done) next_state = ST_WR_VREF2;
            ST_WR_VREF2:    if (ctrl_done) next_state = ST_RD_ADPT;
            ST_RD_ADPT:     if (ctrl_done) next_state = ST_WR_ADPT;
            ST_WR_ADPT:     if (ctrl_done) next_state = ST_IDLE;
            default:        next_state = ST_IDLE;
        endcase
    end

    // channel error at end of a bus cycle aborts
    assign state_nxt = (uif_chan_err && ctrl_done) ? ST_IDLE : next_state;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= ST_IDLE;
            uif_busy     <= 1'b0;
            ctrl_lock    <= 1'b0;
            search_clear <= 1'b0;
            search_run   <= 1'b0;
            ctrl_go_ff   <= 1'b0;
            ctrl_go      <= 1'b0;
        end
        else
        begin
            state        <= state_nxt;
            uif_busy     <= (state_nxt != ST_IDLE);
            ctrl_lock    <= (state_nxt != ST_IDLE) && (state_nxt != ST_WR_ADPT);
            search_clear <= (state_nxt == ST_RD_OFFSET12);
            search_run   <= (state_nxt == ST_WAIT);
            // every move into a bus state starts one bus cycle
            ctrl_go_ff   <= (state_nxt != state) && (state_nxt != ST_IDLE) &&
                            (state_nxt != ST_WAIT);
            // one more cycle so the builder's registers are stable at go
            ctrl_go      <= ctrl_go_ff;
        end
    end

    // VREF/bypass copy for the final restore
    always_ff @(posedge clk)
    begin
        if ((state == ST_RD_VREF) && ctrl_done)
            rmw_data_save <= ctrl_rdata;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            cal_mem <= '0;
        else if ((state == ST_TESTBUS) && ctrl_done)
            cal_mem[ctrl_phys] <= 1'b1;
    end

    assign cal_prior = cal_mem[ctrl_phys];

endmodule

// ==== hdl/cal_write_builder.sv ====
// ########################################
// opcode, address and write data per state
// ########################################
`timescale 1ns/1ps

module cal_write_builder (
    input  logic                                                  clk,
    input  dfe_cal_pkg::cal_state_t                               state,
    input  logic [dfe_cal_pkg::CTRL_DATA_W-1:0]                   ctrl_rdata,
    input  logic [dfe_cal_pkg::CTRL_DATA_W-1:0]                   rmw_data_save,
    input  logic [1:0]                                            uif_wdata,
    input  logic [dfe_cal_pkg::LANES-1:0][dfe_cal_pkg::OFFSET_W-1:0] lane_code,
    output dfe_cal_pkg::ctrl_op_t                                 ctrl_opcode,
    output logic [dfe_cal_pkg::CTRL_ADDR_W-1:0]                   ctrl_addr,
    output logic [dfe_cal_pkg::CTRL_DATA_W-1:0]                   ctrl_wdata
);
    import dfe_cal_pkg::*;

    always_ff @(posedge clk)
    begin
        case (state)
            ST_TESTBUS:
                ctrl_opcode <= CTRL_OP_TBUS;
            ST_WR_PWR, ST_WR_VREF, ST_WR_ADPT_ON, ST_WR_TB_ON, ST_WR_OC_ON,
            ST_WR_OFFSET12, ST_WR_OFFSET15, ST_WR_TB_OFF, ST_WR_OC_OFF,
            ST_WR_VREF2, ST_WR_ADPT:
                ctrl_opcode <= CTRL_OP_WR;
            default:
                ctrl_opcode <= CTRL_OP_RD;
        endcase
    end

    always_ff @(posedge clk)
    begin
        case (state)
            ST_RD_PWR, ST_WR_PWR, ST_RD_OFFSET12, ST_WR_OFFSET12:
                ctrl_addr <= ADDR_DFE12;
            ST_RD_VREF, ST_WR_VREF, ST_WR_VREF2:
                ctrl_addr <= ADDR_DFE13;
            ST_RD_ADPT_ON, ST_WR_ADPT_ON, ST_RD_ADPT, ST_WR_ADPT:
                ctrl_addr <= ADDR_DFE11;
            ST_RD_TB_ON, ST_WR_TB_ON, ST_RD_TB_OFF, ST_WR_TB_OFF:
                ctrl_addr <= ADDR_DFE8;
            ST_RD_OC_ON, ST_WR_OC_ON, ST_RD_OC_OFF, ST_WR_OC_OFF:
                ctrl_addr <= ADDR_OC;
            ST_WR_OFFSET15:
                ctrl_addr <= ADDR_DFE15;
            default:
                ctrl_addr <= '0;
        endcase
    end

    // read data with this state's field replaced
    always_ff @(posedge clk)
    begin
        ctrl_wdata <= ctrl_rdata;
        case (state)
            ST_WR_PWR:
                ctrl_wdata[DFE12_PDB] <= uif_wdata[UIF_PDB];
            ST_WR_VREF:
            begin
                ctrl_wdata[DFE13_VREF_LO +: 3] <= 3'b000;
                ctrl_wdata[DFE13_BYPASS]       <= 1'b1;
            end
            ST_WR_ADPT_ON:
                ctrl_wdata[DFE11_ADAPT] <= 1'b1;
            ST_TESTBUS:
                ctrl_wdata <= TESTBUS_SEL;
            ST_WR_TB_ON:
                ctrl_wdata[DFE8_TB_OE] <= 1'b1;
            ST_WR_OC_ON:
                ctrl_wdata[OC_CALEN] <= 1'b1;
            ST_WR_OFFSET12:
            begin
                ctrl_wdata[DFE12_OD_LO +: OFFSET_W] <= lane_code[0];
                ctrl_wdata[DFE12_EV_LO +: OFFSET_W] <= lane_code[1];
            end
            ST_WR_OFFSET15:
                ctrl_wdata <= {lane_code[5], lane_code[4], lane_code[3], lane_code[2]};
            ST_WR_TB_OFF:
                ctrl_wdata[DFE8_TB_OE] <= 1'b0;
            ST_WR_OC_OFF:
                ctrl_wdata[OC_CALEN] <= 1'b0;
            // bypass is the inverse of the user adapt bit
            ST_WR_VREF2:
            begin
                ctrl_wdata               <= rmw_data_save;
                ctrl_wdata[DFE13_BYPASS] <= ~uif_wdata[UIF_ADAPT];
            end
            ST_WR_ADPT:
                ctrl_wdata[DFE11_ADAPT] <= uif_wdata[UIF_ADAPT];
            default:
                ;
        endcase
    end

endmodule

// ==== hdl/dfe_cal_top.sv ====
// ########################################
// dfe offset calibration top level
// ########################################
`timescale 1ns/1ps

module dfe_cal_top (
    input  logic                                 clk,
    input  logic                                 reset,
    // user side
    input  logic                                 uif_go,
    input  dfe_cal_pkg::uif_mode_t               uif_mode,
    input  logic [dfe_cal_pkg::UIF_ADDR_W-1:0]   uif_addr,
    input  logic [1:0]                           uif_wdata,
    input  logic                                 uif_chan_err,
    output logic                                 uif_busy,
    // basic-block side
    output logic                                 ctrl_go,
    output dfe_cal_pkg::ctrl_op_t                ctrl_opcode,
    output logic                                 ctrl_lock,
    output logic [dfe_cal_pkg::CTRL_ADDR_W-1:0]  ctrl_addr,
    output logic [dfe_cal_pkg::CTRL_DATA_W-1:0]  ctrl_wdata,
    input  logic                                 ctrl_wait,
    input  logic [dfe_cal_pkg::CTRL_DATA_W-1:0]  ctrl_rdata,
    input  logic [dfe_cal_pkg::PHYS_W-1:0]       ctrl_phys,
    input  logic [dfe_cal_pkg::LANES-1:0]        ctrl_testbus
);
    import dfe_cal_pkg::*;

    cal_state_t                      state;
    logic [CTRL_DATA_W-1:0]          rmw_data_save;
    logic                            search_clear;
    logic                            search_run;
    logic                            step_tick;
    logic                            search_done;
    logic [LANES-1:0][OFFSET_W-1:0]  lane_code;

    cal_sequencer cal_sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .uif_go        (uif_go),
        .uif_mode      (uif_mode),
        .uif_addr      (uif_addr),
        .uif_pdb       (uif_wdata[UIF_PDB]),
        .uif_chan_err  (uif_chan_err),
        .ctrl_wait     (ctrl_wait),
        .ctrl_rdata    (ctrl_rdata),
        .ctrl_phys     (ctrl_phys),
        .step_tick     (step_tick),
        .search_done   (search_done),
        .state         (state),
        .uif_busy      (uif_busy),
        .ctrl_go       (ctrl_go),
        .ctrl_lock     (ctrl_lock),
        .search_clear  (search_clear),
        .search_run    (search_run),
        .rmw_data_save (rmw_data_save)
    );

    offset_search offset_search_inst (
        .clk          (clk),
        .reset        (reset),
        .search_clear (search_clear),
        .search_run   (search_run),
        .ctrl_testbus (ctrl_testbus),
        .step_tick    (step_tick),
        .search_done  (search_done),
        .lane_code    (lane_code)
    );

    cal_write_builder cal_write_builder_inst (
        .clk           (clk),
        .state         (state),
        .ctrl_rdata    (ctrl_rdata),
        .rmw_data_save (rmw_data_save),
        .uif_wdata     (uif_wdata),
        .lane_code     (lane_code),
        .ctrl_opcode   (ctrl_opcode),
        .ctrl_addr     (ctrl_addr),
        .ctrl_wdata    (ctrl_wdata)
    );

endmodule

// ==== sim/dfe_cal_tb.sv ====
// ########################################
// dfe calibration testbench: register model,
// testbus lanes, stimulus and checks
// ########################################
`timescale 1ns/1ps

module dfe_cal_tb;
    import dfe_cal_pkg::*;

    localparam logic [31:0] SEED = 32'hfab3;
    // one calibration runs about 2400 cycles, this allows roughly eight
    localparam int MAX_CYCLES = 20000;

    logic                    clk;
    logic                    reset;
    logic                    uif_go;
    uif_mode_t               uif_mode;
    logic [UIF_ADDR_W-1:0]   uif_addr;
    logic [1:0]              uif_wdata;
    logic                    uif_chan_err;
    logic                    uif_busy;
    logic                    ctrl_go;
    ctrl_op_t                ctrl_opcode;
    logic                    ctrl_lock;
    logic [CTRL_ADDR_W-1:0]  ctrl_addr;
    logic [CTRL_DATA_W-1:0]  ctrl_wdata;
    logic                    ctrl_wait;
    logic [CTRL_DATA_W-1:0]  ctrl_rdata;
    logic [PHYS_W-1:0]       ctrl_phys;
    logic [LANES-1:0]        ctrl_testbus;

    // basic-block model state
    logic [CTRL_DATA_W-1:0]  regs [0:2**CTRL_ADDR_W-1];
    ctrl_op_t                op_code;
    logic [CTRL_ADDR_W-1:0]  op_addr;
    logic [CTRL_DATA_W-1:0]  op_data;
    int                      wait_left;
    int                      go_count;
    int                      tbus_ops;
    logic                    last_dfe11_lock;
    logic [2**PHYS_W-1:0]    cal_seen;
    logic                    busy_seen;

    // toggle windows per lane
    int                      win_lo [LANES];
    int                      win_hi [LANES];
    logic [LANES-1:0]        has_win;

    int                      value_errors;
    int                      handshake_errors;
    int                      cycle;

    dfe_cal_top dfe_cal_top_inst (
        .clk          (clk),
        .reset        (reset),
        .uif_go       (uif_go),
        .uif_mode     (uif_mode),
        .uif_addr     (uif_addr),
        .uif_wdata    (uif_wdata),
        .uif_chan_err (uif_chan_err),
        .uif_busy     (uif_busy),
        .ctrl_go      (ctrl_go),
        .ctrl_opcode  (ctrl_opcode),
        .ctrl_lock    (ctrl_lock),
        .ctrl_addr    (ctrl_addr),
        .ctrl_wdata   (ctrl_wdata),
        .ctrl_wait    (ctrl_wait),
        .ctrl_rdata   (ctrl_rdata),
        .ctrl_phys    (ctrl_phys),
        .ctrl_testbus (ctrl_testbus)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic expect_equal(input string what, input int got, input int expected);
        assert (got == expected)
        else
        begin
            value_errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // lane code as currently written into DFE12/DFE15
    function automatic logic [OFFSET_W-1:0] written_code(input int lane);
        logic [CTRL_DATA_W-1:0] w;
        if (lane == 0)
            return regs[ADDR_DFE12][DFE12_OD_LO +: OFFSET_W];
        if (lane == 1)
            return regs[ADDR_DFE12][DFE12_EV_LO +: OFFSET_W];
        w = regs[ADDR_DFE15];
        return w[(lane - 2) * OFFSET_W +: OFFSET_W];
    endfunction

    // register model, wait held 1..4 cycles after each go
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (ctrl_go)
            begin
                op_code   = ctrl_opcode;
                op_addr   = ctrl_addr;
                op_data   = ctrl_wdata;
                wait_left = 1 + ($urandom % 4);
                go_count++;
                ctrl_wait <= 1'b1;
                if ((ctrl_opcode == CTRL_OP_WR) && (ctrl_addr == ADDR_DFE11))
                    last_dfe11_lock = ctrl_lock;
            end
            else if (ctrl_wait)
            begin
                wait_left--;
                if (wait_left == 0)
                begin
                    ctrl_wait <= 1'b0;
                    case (op_code)
                        CTRL_OP_RD:
                            ctrl_rdata <= regs[op_addr];
                        CTRL_OP_WR:
                            regs[op_addr] = op_data;
                        CTRL_OP_TBUS:
                        begin
                            tbus_ops++;
                            cal_seen[ctrl_phys] = 1'b1;
                            expect_equal("testbus select value", op_data, TESTBUS_SEL);
                        end
                        default:
                            ;
                    endcase
                end
            end
        end
    end

    // a lane toggles every cycle while its code is inside the window
    always @(posedge clk)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            if (has_win[i] && (written_code(i) >= win_lo[i]) && (written_code(i) <= win_hi[i]))
                ctrl_testbus[i] <= ~ctrl_testbus[i];
        end
    end

    always @(posedge clk)
    begin
        if (uif_busy)
            busy_seen <= 1'b1;
    end

    a_go_single: assert property (@(posedge clk) disable iff (reset) ctrl_go |=> !ctrl_go)
    else
    begin
        handshake_errors++;
        $display("ctrl_go stayed high for more than one cycle at %0t", $time);
    end

    a_go_no_wait: assert property (@(posedge clk) disable iff (reset) ctrl_go |-> !ctrl_wait)
    else
    begin
        handshake_errors++;
        $display("ctrl_go issued while ctrl_wait was high at %0t", $time);
    end

    a_go_busy: assert property (@(posedge clk) disable iff (reset) ctrl_go |-> uif_busy)
    else
    begin
        handshake_errors++;
        $display("bus activity without uif_busy at %0t", $time);
    end

    // error seen at the end of a bus cycle ends the sequence
    a_err_abort: assert property (@(posedge clk) disable iff (reset)
        ($fell(ctrl_wait) && uif_chan_err) |-> ##2 !uif_busy)
    else
    begin
        handshake_errors++;
        $display("uif_busy still high after a bus cycle with channel error at %0t", $time);
    end

    task automatic pick_windows();
        for (int i = 0; i < LANES; i++)
        begin
            win_lo[i] = $urandom % NUM_STEPS;
            win_hi[i] = win_lo[i] + ($urandom % (NUM_STEPS - win_lo[i]));
            // roughly a third of the lanes never toggle
            has_win[i] = ($urandom % 3) != 0;
        end
    endtask

    task automatic start_request(input uif_mode_t mode, input logic [UIF_ADDR_W-1:0] addr,
                                 input logic [PHYS_W-1:0] phys, input logic [1:0] data);
        @(posedge clk);
        ctrl_phys <= phys;
        uif_mode  <= mode;
        uif_addr  <= addr;
        uif_wdata <= data;
        uif_go    <= 1'b1;
        @(posedge clk);
        uif_go <= 1'b0;
    endtask

    task automatic wait_sequence_end();
        do @(negedge clk); while (!uif_busy);
        do @(negedge clk); while (uif_busy);
    endtask

    // full control write, then compare registers with the expected result
    task automatic run_write(input logic [PHYS_W-1:0] phys, input logic [1:0] data);
        logic                   expect_cal;
        logic [CTRL_DATA_W-1:0] exp13;
        int                     tbus_before;
        int                     exp_code;
        expect_cal  = data[UIF_PDB] && !cal_seen[phys];
        exp13       = regs[ADDR_DFE13];
        exp13[DFE13_BYPASS] = ~data[UIF_ADAPT];
        tbus_before = tbus_ops;
        @(negedge clk);
        pick_windows();
        start_request(UIF_MODE_WR, USER_CTRL_ADDR, phys, data);
        wait_sequence_end();
        expect_equal("testbus operations", tbus_ops - tbus_before, expect_cal ? 1 : 0);
        expect_equal("DFE12 power bit", regs[ADDR_DFE12][DFE12_PDB], data[UIF_PDB]);
        expect_equal("DFE13 after restore", regs[ADDR_DFE13], exp13);
        expect_equal("DFE11 adapt bit", regs[ADDR_DFE11][DFE11_ADAPT], data[UIF_ADAPT]);
        expect_equal("lock on final DFE11 write", last_dfe11_lock, 0);
        if (expect_cal)
        begin
            expect_equal("DFE8 testbus buffer", regs[ADDR_DFE8][DFE8_TB_OE], 0);
            expect_equal("OC calibration enable", regs[ADDR_OC][OC_CALEN], 0);
            for (int i = 0; i < LANES; i++)
            begin
                exp_code = has_win[i] ? (win_lo[i] + win_hi[i]) / 2 : OFFSET_MID;
                expect_equal($sformatf("lane %0d offset", i), written_code(i), exp_code);
            end
        end
    endtask

    task automatic request_ignored(input uif_mode_t mode, input logic [UIF_ADDR_W-1:0] addr);
        int gos_before;
        gos_before = go_count;
        busy_seen  = 1'b0;
        start_request(mode, addr, 7'd33, 2'b11);
        // no handshake follows, so allow the FSM a few cycles
        repeat (16) @(negedge clk);
        expect_equal("bus cycles on ignored request", go_count - gos_before, 0);
        expect_equal("busy on ignored request", busy_seen, 0);
    endtask

    task automatic abort_on_error(input logic [PHYS_W-1:0] phys, input int at_go);
        int gos_before;
        gos_before = go_count;
        @(negedge clk);
        pick_windows();
        start_request(UIF_MODE_WR, USER_CTRL_ADDR, phys, 2'b11);
        do @(negedge clk); while (go_count - gos_before < at_go);
        @(posedge clk);
        uif_chan_err <= 1'b1;
        do @(negedge clk); while (uif_busy);
        @(posedge clk);
        uif_chan_err <= 1'b0;
        repeat (8) @(negedge clk);
        expect_equal("bus cycles before abort", go_count - gos_before, at_go);
    endtask

    initial
    begin
        void'($urandom(SEED));
        for (int a = 0; a < 2**CTRL_ADDR_W; a++)
            regs[a] = CTRL_DATA_W'(a * 40503 + (a >> 5)) ^ CTRL_DATA_W'(a);
        value_errors     = 0;
        handshake_errors = 0;
        go_count         = 0;
        tbus_ops         = 0;
        wait_left        = 0;
        last_dfe11_lock  = 1'b1;
        cal_seen         = '0;
        busy_seen        = 1'b0;
        has_win          = '0;
        reset        = 1'b1;
        uif_go       = 1'b0;
        uif_mode     = UIF_MODE_RD;
        uif_addr     = '0;
        uif_wdata    = 2'b00;
        uif_chan_err = 1'b0;
        ctrl_wait    = 1'b0;
        ctrl_rdata   = '0;
        ctrl_phys    = '0;
        ctrl_testbus = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_equal("uif_busy after reset", uif_busy, 0);
        expect_equal("ctrl_go after reset", ctrl_go, 0);
        expect_equal("ctrl_lock after reset", ctrl_lock, 0);

        // first power-on calibrates, second one on the same channel does not
        run_write(7'd5, 2'b11);
        run_write(7'd5, 2'b10);
        run_write(7'd9, 2'b00);
        run_write(7'd9, 2'b11);
        run_write(7'd9, 2'b01);

        request_ignored(UIF_MODE_WR, USER_CTRL_ADDR + 1'b1);
        request_ignored(UIF_MODE_RD, USER_CTRL_ADDR);
        request_ignored(UIF_MODE_PHYS, USER_CTRL_ADDR);

        // abort on the tenth bus cycle, after the testbus select
        abort_on_error(7'd20, 10);
        run_write(7'd20, 2'b11);

        $display("errors: value %0d, handshake %0d", value_errors, handshake_errors);
        if ((value_errors == 0) && (handshake_errors == 0))
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        cycle = 0;
        while (cycle < MAX_CYCLES)
        begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/dfe_cal_pkg.sv
hdl/offset_lane.sv
hdl/offset_search.sv
hdl/cal_sequencer.sv
hdl/cal_write_builder.sv
hdl/dfe_cal_top.sv
sim/dfe_cal_tb.sv

// ==== Bender.yml ====
package:
  name: dfe_cal

sources:
  - hdl/dfe_cal_pkg.sv
  - hdl/offset_lane.sv
  - hdl/offset_search.sv
  - hdl/cal_sequencer.sv
  - hdl/cal_write_builder.sv
  - hdl/dfe_cal_top.sv
  - target: simulation
    files:
      - sim/dfe_cal_tb.sv
